/* compile.f */
+incdir+common
common/cpack_pkg.sv
cpack/cpack_compact.sv
cpack/cpack_dsf.sv
hw/cpack_fifo.sv
hw/cpack_req_ack_tx.sv
hw/adc_cpack_top.sv
testbench/tb_adc_cpack.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ADC capture path testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_adc_cpack \
  --Mdir build \
  -o sim_tb

./build/sim_tb | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* testbench/tb_adc_cpack.sv */
// testbench for the adc capture path, drives sample sets under several masks and checks the req/ack link
`timescale 1ns/1ps
`include "cpack_params.svh"

module tb_adc_cpack
  import cpack_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  // sample sets over all runs, in run order
  localparam int NUM_SETS   = 12 + 16 + 15 + 5 + 9 + 14;
  // a paced set can wait for roughly one full handshake
  localparam int SET_CYCLES = 16;
  // with ack held the link keeps one word in its holding register and a full FIFO behind it
  localparam int KEEP_OVF   = `CPACK_FIFO_DEPTH + 1;

  logic                       adc_clk;
  logic                       reset;
  logic                       adc_valid;
  adc_sample_t                adc_data;
  logic [`CPACK_NUM_CH-1:0]   adc_enable_mask;
  logic                       req;
  logic                       ack;
  cpack_beat_t                link_beat;
  logic                       overflow;

  // expected words in link order, and channels that have not yet filled a word
  cpack_beat_t                ref_q[$];
  logic [`CPACK_CH_WIDTH-1:0] pend_val[$];
  logic                       pend_first[$];
  cpack_beat_t                exp_beat;
  int                         set_idx;
  int                         errors;
  int                         words_seen;
  int                         ovf_made;
  logic                       sink_hold;
  logic                       ovf_test;

  adc_cpack_top dut_i (.*);

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  // ****************************************
  // reference model
  // ****************************************

  // channel c of set k is {c, k}, enabled channels line up four to a word
  // slot 0 of a word carries the sync flag of the channel that landed there
  task automatic model_set(input logic [3:0] m, input int k);
    cpack_beat_t b;
    logic        first;
    first = 1'b1;
    for (int c = 0; c < `CPACK_NUM_CH; c++) begin
      if (m[c]) begin
        pend_val.push_back({c[3:0], k[11:0]});
        pend_first.push_back(first);
        first = 1'b0;
      end
    end
    while (pend_val.size() >= `CPACK_SLOTS) begin
      b.sync = pend_first[0];
      for (int i = 0; i < `CPACK_SLOTS; i++) begin
        b.word.slot[i] = pend_val.pop_front();
        void'(pend_first.pop_front());
      end
      // words past the FIFO and the holding register are lost during the overflow run
      if (!ovf_test || ovf_made < KEEP_OVF) begin
        ref_q.push_back(b);
      end
      if (ovf_test) begin
        ovf_made++;
      end
    end
  endtask

  // ****************************************
  // stimulus
  // ****************************************

  // one strobe per set, paced so the FIFO stays far from full in normal runs
  task automatic send_set(input int gap, input bit pace);
    while (pace && ref_q.size() > 4) begin
      @(negedge adc_clk);
    end
    @(negedge adc_clk);
    adc_valid = 1'b1;
    for (int c = 0; c < `CPACK_NUM_CH; c++) begin
      adc_data.ch[c] = {c[3:0], set_idx[11:0]};
    end
    model_set(adc_enable_mask, set_idx);
    set_idx++;
    @(negedge adc_clk);
    adc_valid = 1'b0;
    repeat (gap) @(negedge adc_clk);
  endtask

  task automatic run_mask(input logic [3:0] m, input int sets, input bit pace);
    @(negedge adc_clk);
    // a new mask throws away the partial word in the DUT, and in the model too
    if (m != adc_enable_mask) begin
      pend_val.delete();
      pend_first.delete();
    end
    adc_enable_mask = m;
    repeat (2) @(negedge adc_clk);
    for (int s = 0; s < sets; s++) begin
      send_set(pace ? int'($urandom_range(2, 0)) : 0, pace);
    end
  endtask

  // every expected word delivered and the link back at rest
  task automatic drain();
    while (ref_q.size() != 0 || req || ack) begin
      @(negedge adc_clk);
    end
  endtask

  // ****************************************
  // sink model
  // ****************************************

  // ack follows req one cycle late at the earliest, so req is never seen rising under ack
  initial begin
    int d;
    ack = 1'b0;
    forever begin
      @(negedge adc_clk);
      if (req && !sink_hold) begin
        d = $urandom_range(5, 0);
        repeat (d + 1) @(negedge adc_clk);
        no_extra_word: assert (ref_q.size() != 0) else begin
          errors++;
          $display("link delivered a word that the model did not expect");
        end
        if (ref_q.size() != 0) begin
          exp_beat = ref_q.pop_front();
        end
        ack = 1'b1;
        words_seen++;
        while (req) begin
          @(negedge adc_clk);
        end
        d = $urandom_range(5, 0);
        repeat (d) @(negedge adc_clk);
        ack = 1'b0;
      end
    end
  end

  // ****************************************
  // checks
  // ****************************************

  word_check: assert property (@(posedge adc_clk) disable iff (reset)
    $rose(ack) |-> (link_beat == exp_beat)) else begin
    errors++;
    $display("FAILED link_beat: got %h, expected %h", $sampled(link_beat), exp_beat);
  end

  ack_needs_req: assert property (@(posedge adc_clk) disable iff (reset)
    $rose(ack) |-> req) else begin
    errors++;
    $display("ack rose while req was low");
  end

  req_after_ack: assert property (@(posedge adc_clk) disable iff (reset)
    $rose(req) |-> !ack) else begin
    errors++;
    $display("req rose while ack was still high");
  end

  data_hold: assert property (@(posedge adc_clk) disable iff (reset)
    (req && $past(req)) |-> $stable(link_beat)) else begin
    errors++;
    $display("FAILED link_beat: got %h, expected %h", $sampled(link_beat), $past(link_beat));
  end

  // outside the overflow run nothing may be dropped
  no_overflow: assert property (@(posedge adc_clk) disable iff (reset)
    !ovf_test |-> !overflow) else begin
    errors++;
    $display("FAILED overflow: got %h, expected 0", $sampled(overflow));
  end

  // ****************************************
  // main sequence and watchdog
  // ****************************************

  initial begin
    void'($urandom(32'h47f4));
    reset           = 1'b1;
    adc_valid       = 1'b0;
    adc_data        = '0;
    adc_enable_mask = '0;
    exp_beat        = '0;
    set_idx         = 0;
    errors          = 0;
    words_seen      = 0;
    ovf_made        = 0;
    sink_hold       = 1'b0;
    ovf_test        = 1'b0;
    repeat (4) @(negedge adc_clk);
    reset = 1'b0;
    run_mask(4'b1111, 12, 1'b1);
    run_mask(4'b0101, 16, 1'b1);
    run_mask(4'b0111, 15, 1'b1);
    // leftovers of both of these runs are cut off by the next mask
    run_mask(4'b1110, 5, 1'b1);
    run_mask(4'b1011, 9, 1'b1);
    drain();
    // sink stalls while sets arrive far faster than words can leave
    sink_hold = 1'b1;
    ovf_test  = 1'b1;
    run_mask(4'b1111, 14, 1'b0);
    repeat (4) @(negedge adc_clk);
    overflow_seen: assert (overflow) else begin
      errors++;
      $display("FAILED overflow: got %h, expected 1", overflow);
    end
    sink_hold = 1'b0;
    drain();
    repeat (20) @(negedge adc_clk);
    $display("words checked %0d, errors %0d", words_seen, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(20 * NUM_SETS * SET_CYCLES * CLK_PERIOD);
    $display("timeout, the link stopped delivering words after %0d of them", words_seen);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* hw/adc_cpack_top.sv */
// top of the adc capture path, compactor into packer into FIFO into the req/ack link
`timescale 1ns/1ps
`include "cpack_params.svh"

module adc_cpack_top
  import cpack_pkg::*;
(
  input  logic                     adc_clk,
  input  logic                     reset,
  input  logic                     adc_valid,
  input  adc_sample_t              adc_data,
  input  logic [`CPACK_NUM_CH-1:0] adc_enable_mask,
  output logic                     req,
  input  logic                     ack,
  output cpack_beat_t              link_beat,
  output logic                     overflow
);

  // ****************************************
  // internal links
  // ****************************************

  compact_beat_t compact;
  cpack_beat_t   dsf_beat;
  logic          dsf_valid;
  cpack_beat_t   fifo_beat;
  logic          fifo_empty;
  logic          fifo_pop;

  // keeps the enabled channels of each sample set, one cycle after the strobe
  cpack_compact u_compact (
    .adc_clk         (adc_clk),
    .reset           (reset),
    .adc_valid       (adc_valid),
    .adc_data        (adc_data),
    .adc_enable_mask (adc_enable_mask),
    .compact         (compact)
  );

  // packs the compacted channels into full words with a sample-set sync flag
  cpack_dsf u_dsf (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .compact   (compact),
    .dsf_beat  (dsf_beat),
    .dsf_valid (dsf_valid)
  );

  // absorbs the gap between the adc rate and the handshake rate
  cpack_fifo u_fifo (
    .adc_clk  (adc_clk),
    .reset    (reset),
    .wr_valid (dsf_valid),
    .wr_beat  (dsf_beat),
    .rd_pop   (fifo_pop),
    .rd_beat  (fifo_beat),
    .empty    (fifo_empty),
    .overflow (overflow)
  );

  cpack_req_ack_tx u_tx (
    .adc_clk    (adc_clk),
    .reset      (reset),
    .fifo_beat  (fifo_beat),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .req        (req),
    .ack        (ack),
    .link_beat  (link_beat)
  );

endmodule

/* hw/cpack_req_ack_tx.sv */
// four-phase req/ack transmitter, drains the FIFO one packed word at a time toward the dma side
`timescale 1ns/1ps

module cpack_req_ack_tx
  import cpack_pkg::*;
(
  input  logic        adc_clk,
  input  logic        reset,
  input  cpack_beat_t fifo_beat,
  input  logic        fifo_empty,
  output logic        fifo_pop,
  output logic        req,
  input  logic        ack,
  output cpack_beat_t link_beat
);

  // ****************************************
  // handshake FSM
  // ****************************************

  // idle, then req high waiting for ack, then req low waiting for ack to fall
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_WAIT_ACK_HI,
    TX_WAIT_ACK_LO
  } tx_state_t;

  tx_state_t state;

  // start a transfer only from idle with the sink back at rest
  // the head word is taken in the same cycle that req is set
  assign fifo_pop = (state == TX_IDLE) && !fifo_empty && !ack;

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      state <= TX_IDLE;
      req   <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (fifo_pop) begin
            req   <= 1'b1;
            state <= TX_WAIT_ACK_HI;
          end
        end
        TX_WAIT_ACK_HI: begin
          // sink has the data, release req
          if (ack) begin
            req   <= 1'b0;
            state <= TX_WAIT_ACK_LO;
          end
        end
        TX_WAIT_ACK_LO: begin
          // the next transfer may begin in the cycle after ack is seen low
          if (!ack) begin
            state <= TX_IDLE;
          end
        end
        default: begin
          req   <= 1'b0;
          state <= TX_IDLE;
        end
      endcase
    end
  end

  // holding register, loaded at pop and left alone for the rest of the transfer
  always_ff @(posedge adc_clk) begin
    if (fifo_pop) begin
      link_beat <= fifo_beat;
    end
  end

  // data may not move under a raised req
  assert property (@(posedge adc_clk) disable iff (reset)
    (req && $past(req)) |-> $stable(link_beat));

  // req never rises while the sink still drives ack from the previous transfer
  assert property (@(posedge adc_clk) disable iff (reset) $rose(req) |-> !ack);

endmodule

/* hw/cpack_fifo.sv */
// first-word-fall-through FIFO of packed words between the packer and the req/ack transmitter
`timescale 1ns/1ps
`include "cpack_params.svh"

module cpack_fifo
  import cpack_pkg::*;
(
  input  logic        adc_clk,
  input  logic        reset,
  input  logic        wr_valid,
  input  cpack_beat_t wr_beat,
  input  logic        rd_pop,
  output cpack_beat_t rd_beat,
  output logic        empty,
  output logic        overflow
);

  localparam int DEPTH  = `CPACK_FIFO_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int WORD_W = `CPACK_SLOTS * `CPACK_CH_WIDTH;

  // word and sync kept side by side, the word is stored as plain bits
  logic [WORD_W-1:0] mem_word [DEPTH];
  logic              mem_sync [DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              full;
  logic              do_write;
  logic              do_pop;

  // pointer step with wrap, works for depths that are not a power of two as well
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  // the adc cannot stall, a write into a full FIFO is lost
  assign do_write = wr_valid && !full;
  assign do_pop   = rd_pop && !empty;

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_write) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_write, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // stays up until reset so software can see that data was lost
      if (wr_valid && full) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (do_write) begin
      mem_word[wr_ptr] <= wr_beat.word.raw;
      mem_sync[wr_ptr] <= wr_beat.sync;
    end
  end

  // head entry is visible before it is popped
  assign rd_beat.word.raw = mem_word[rd_ptr];
  assign rd_beat.sync     = mem_sync[rd_ptr];

  // the transmitter only pops when it sees data
  assert property (@(posedge adc_clk) disable iff (reset) rd_pop |-> !empty);

endmodule

/* cpack/cpack_dsf.sv */
// store-and-forward packer, appends compacted channels to a slot store and emits full words
`timescale 1ns/1ps
`include "cpack_params.svh"

module cpack_dsf
  import cpack_pkg::*;
(
  input  logic          adc_clk,
  input  logic          reset,
  input  compact_beat_t compact,
  output cpack_beat_t   dsf_beat,
  output logic          dsf_valid
);

  // worst case the store holds three leftovers plus four new channels, so twice a word is enough
  localparam int STORE_SLOTS = 2 * `CPACK_SLOTS;
  localparam int FILL_W      = $clog2(STORE_SLOTS);
  localparam int TOT_W       = FILL_W + 1;

  // ****************************************
  // state
  // ****************************************

  // slot store, slot 0 is the oldest channel waiting for a word
  logic [STORE_SLOTS-1:0][`CPACK_CH_WIDTH-1:0] store;
  // one flag per slot, set when that slot held the first enabled channel of a sample set
  logic [STORE_SLOTS-1:0]                      store_first;
  // number of valid slots in the store, always below one word after an update
  logic [FILL_W-1:0]                           fill;

  // ****************************************
  // merge of store and new beat
  // ****************************************

  logic [FILL_W-1:0]                           base;
  logic [TOT_W-1:0]                            total;
  logic                                        word_ready;
  logic [STORE_SLOTS-1:0][`CPACK_CH_WIDTH-1:0] merged;
  logic [STORE_SLOTS-1:0]                      merged_first;
  cpack_word_u                                 word;

  // a restart discards whatever was left over, so the new beat lands at slot 0
  assign base       = compact.restart ? '0 : fill;
  assign total      = TOT_W'(base) + TOT_W'(compact.count);
  assign word_ready = (total >= TOT_W'(`CPACK_SLOTS));

  // new channels go right after the stored ones
  // slot 0 of a beat is always the first enabled channel of its sample set
  always_comb begin
    int off;
    merged       = store;
    merged_first = store_first;
    for (int k = 0; k < STORE_SLOTS; k++) begin
      off = k - int'(base);
      if (off >= 0) begin
        merged[k]       = '0;
        merged_first[k] = 1'b0;
        if (off < int'(compact.count)) begin
          merged[k]       = compact.ch[off];
          merged_first[k] = (off == 0);
        end
      end
    end
  end

  // the oldest four slots make up the outgoing word
  assign word.slot = merged[`CPACK_SLOTS-1:0];

  // ****************************************
  // fill level and output strobe
  // ****************************************

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      fill      <= '0;
      dsf_valid <= 1'b0;
    end else begin
      dsf_valid <= 1'b0;
      if (compact.valid) begin
        if (word_ready) begin
          fill      <= FILL_W'(total - TOT_W'(`CPACK_SLOTS));
          dsf_valid <= 1'b1;
        end else begin
          fill <= total[FILL_W-1:0];
        end
      end else if (compact.restart) begin
        // mask moved with no data in the same cycle, just drop the leftovers
        fill <= '0;
      end
    end
  end

  // ****************************************
  // payload
  // ****************************************

  // when a word leaves, the remaining slots slide down by one word
  always_ff @(posedge adc_clk) begin
    if (compact.valid) begin
      if (word_ready) begin
        store         <= merged >> (`CPACK_SLOTS * `CPACK_CH_WIDTH);
        store_first   <= merged_first >> `CPACK_SLOTS;
        dsf_beat.word <= word;
        dsf_beat.sync <= merged_first[0];
      end else begin
        store       <= merged;
        store_first <= merged_first;
      end
    end
  end

  // leftovers never reach a full word, otherwise a word would have been held back
  assert property (@(posedge adc_clk) disable iff (reset)
    compact.valid |=> (fill < FILL_W'(`CPACK_SLOTS)));

endmodule

/* cpack/cpack_compact.sv */
// channel compactor, registers each sample set with only its enabled channels moved to the low slots
`timescale 1ns/1ps
`include "cpack_params.svh"

module cpack_compact
  import cpack_pkg::*;
(
  input  logic                     adc_clk,
  input  logic                     reset,
  input  logic                     adc_valid,
  input  adc_sample_t              adc_data,
  input  logic [`CPACK_NUM_CH-1:0] adc_enable_mask,
  output compact_beat_t            compact
);

  localparam int CNT_W = $clog2(`CPACK_NUM_CH + 1);

  // mask seen in the previous cycle, used only to spot a change
  logic [`CPACK_NUM_CH-1:0]                      mask_q;

  // combinational result of the priority compaction
  logic [`CPACK_NUM_CH-1:0][`CPACK_CH_WIDTH-1:0] packed_ch;
  logic [CNT_W-1:0]                              packed_cnt;

  // output registers
  logic [`CPACK_NUM_CH-1:0][`CPACK_CH_WIDTH-1:0] ch_q;
  logic [CNT_W-1:0]                              count_q;
  logic                                          valid_q;
  logic                                          restart_q;

  // ****************************************
  // compaction
  // ****************************************

  // walk the channels in ascending order and drop each enabled one into the next free slot
  // slots past the count stay zero so the packer never sees stale data there
  always_comb begin
    int n;
    n         = 0;
    packed_ch = '0;
    for (int c = 0; c < `CPACK_NUM_CH; c++) begin
      if (adc_enable_mask[c]) begin
        packed_ch[n] = adc_data.ch[c];
        n            = n + 1;
      end
    end
    packed_cnt = CNT_W'(n);
  end

  // ****************************************
  // registers
  // ****************************************

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      mask_q    <= '0;
      restart_q <= 1'b0;
      valid_q   <= 1'b0;
      count_q   <= '0;
    end else begin
      mask_q    <= adc_enable_mask;
      // the packer has to throw away any partial word built under the old mask
      restart_q <= (adc_enable_mask != mask_q);
      // an all-disabled mask produces nothing to pack
      valid_q   <= adc_valid && (packed_cnt != '0);
      if (adc_valid) begin
        count_q <= packed_cnt;
      end
    end
  end

  // channel payload only moves on a strobe
  always_ff @(posedge adc_clk) begin
    if (adc_valid) begin
      ch_q <= packed_ch;
    end
  end

  assign compact.ch      = ch_q;
  assign compact.count   = count_q;
  assign compact.restart = restart_q;
  assign compact.valid   = valid_q;

  // a valid beat carries between one and all of the channels
  assert property (@(posedge adc_clk) disable iff (reset)
    compact.valid |-> (compact.count != '0) && (compact.count <= CNT_W'(`CPACK_NUM_CH)));

endmodule

/* common/cpack_pkg.sv */
// shared types for the adc capture path, imported by every block between the adc and the link
package cpack_pkg;

`include "cpack_params.svh"

  // ****************************************
  // adc side
  // ****************************************

  // one sample set as it comes from the converter
  // channel 0 sits in the low bits
  typedef struct packed {
    logic [`CPACK_NUM_CH-1:0][`CPACK_CH_WIDTH-1:0] ch;
  } adc_sample_t;

  // output of the compactor
  // enabled channels sit in the low slots, count says how many of them are real
  // restart is a one-cycle flag raised after the enable mask moved
  typedef struct packed {
    logic [`CPACK_NUM_CH-1:0][`CPACK_CH_WIDTH-1:0] ch;
    logic [$clog2(`CPACK_NUM_CH + 1)-1:0]          count;
    logic                                          restart;
    logic                                          valid;
  } compact_beat_t;

  // ****************************************
  // packed word side
  // ****************************************

  // the packer builds a word slot by slot, the FIFO and the link just move raw bits
  typedef union packed {
    logic [`CPACK_SLOTS-1:0][`CPACK_CH_WIDTH-1:0] slot;
    logic [`CPACK_SLOTS*`CPACK_CH_WIDTH-1:0]      raw;
  } cpack_word_u;

  // one FIFO entry and one link payload
  // sync marks a word whose slot 0 is the first enabled channel of a sample set
  typedef struct packed {
    cpack_word_u word;
    logic        sync;
  } cpack_beat_t;

endpackage

/* common/cpack_params.svh */
// sizing macros for the adc channel packer, included by the package and by each rtl block
`ifndef CPACK_PARAMS_SVH
`define CPACK_PARAMS_SVH

// ****************************************
// channel geometry
// ****************************************

// bits carried by one adc channel
`define CPACK_CH_WIDTH 16

// adc channels presented per sample set
`define CPACK_NUM_CH 4

// channel slots in one packed output word, so a word is CPACK_SLOTS * CPACK_CH_WIDTH wide
`define CPACK_SLOTS 4

// ****************************************
// buffering
// ****************************************

// packed words the FIFO can hold between the packer and the req/ack link
`define CPACK_FIFO_DEPTH 8

`endif
